//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sdram_ctrl
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

//--- common/sdram_cfg.svh
`ifndef SDRAM_CFG_SVH
`define SDRAM_CFG_SVH

// client word address per bank, row bits on top of column bits
`define SDRAM_AW     22
`define SDRAM_ROW_W  13
`define SDRAM_COL_W  9

// cas latency in clock cycles
`define SDRAM_CL     2

// beats of 16 bits per 64-bit client word
`define SDRAM_BURST  4

// activate to activate spacing across banks
`define SDRAM_TRRD   2

// precharge to activate, and activate to read/write
`define SDRAM_TRP    2
`define SDRAM_TRCD   2

`endif

//--- common/sdram_pkg.sv
`include "sdram_cfg.svh"

package sdram_pkg;

    // {cs_n, ras_n, cas_n, we_n}, all lines active low
    typedef enum logic [3:0] {
        cmd_precharge  = 4'b0010,
        cmd_active     = 4'b0011,
        cmd_write      = 4'b0100,
        cmd_read       = 4'b0101,
        cmd_burst_stop = 4'b0110,
        cmd_nop        = 4'b0111
    } sdram_cmd_e;

    typedef enum logic [2:0] {
        st_idle,        // waiting for a request, decides the next command
        st_precharging, // trp wait, row closed afterwards
        st_activating,  // trcd wait, row open afterwards
        st_accessing,   // read issued, cas latency running
        st_data_phase,  // beats on dq
        st_write_done   // write recovery before the row may close
    } bank_state_e;

    // client request toward one bank engine
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [`SDRAM_AW-1:0]  addr;
    } bank_req_t;

    // one engine's pins and status toward the arbiter
    typedef struct packed {
        sdram_cmd_e               cmd;      // nop unless granted
        logic [`SDRAM_ROW_W-1:0]  addr;     // zero unless granted, so it can be ORed
        logic                     br;       // bus request
        logic                     dq_busy;  // dq in use, first to last beat
        logic                     dqm_busy; // dqm window of the burst in flight
        logic                     act;      // activate on the pins this cycle
        logic                     ack;      // read/write command taken
        logic                     dst;      // first data beat
        logic                     dok;      // any data beat
        logic                     wr_burst; // burst in flight is a write
    } bank_bus_t;

endpackage

//--- project.f
+incdir+common
common/sdram_pkg.sv
sdram_bank/sdram_bank.sv
sdram_bank/sdram_bus_arb.sv
source/sdram_wb_port.sv
source/sdram_ctrl_top.sv
verif/sdram_model.sv
verif/tb_sdram_ctrl.sv

//--- sdram_bank/sdram_bank.sv
`timescale 1ns/1ns
`include "sdram_cfg.svh"

module sdram_bank (
    input  logic                 clk,
    input  logic                 rst,
    input  sdram_pkg::bank_req_t req,
    input  logic                 grant,
    input  logic                 all_dq_busy, // other bank holds dq
    input  logic                 all_dqm,     // other bank holds the dqm window
    input  logic                 all_act,     // other bank activated within trrd
    output sdram_pkg::bank_bus_t bus
);

localparam int BL_W  = $clog2(`SDRAM_BURST);
localparam int PAD_W = `SDRAM_ROW_W - `SDRAM_COL_W; // a12..a9 during read/write

sdram_pkg::bank_state_e  st;
logic [BL_W-1:0]         cnt;     // wait and beat counter
logic [`SDRAM_ROW_W-1:0] row;     // open row
logic                    row_ok;  // a row is open
logic                    wr_kind; // burst in flight is a write

logic [`SDRAM_ROW_W-1:0] req_row;
logic                    hit;
logic                    want_pre;
logic                    want_act;
logic                    want_rw;
logic                    br;
logic                    do_pre;
logic                    do_act;
logic                    do_rw;
logic                    last_beat;

assign req_row = req.addr[`SDRAM_AW-1 -: `SDRAM_ROW_W];
assign hit     = row_ok && row == req_row;

// what idle would issue now, flags already applied
assign want_pre = row_ok && !hit;                       // wrong row open
assign want_act = !row_ok && !all_act;                  // trrd across banks
assign want_rw  = hit && !all_dq_busy && !all_dqm;      // data bus must be free

// blocked engines drop the request so the other bank gets the bus
assign br = req.valid && st == sdram_pkg::st_idle && (want_pre || want_act || want_rw);

assign do_pre = br && grant && want_pre;
assign do_act = br && grant && want_act;
assign do_rw  = br && grant && want_rw;

// write data phase starts one beat in, at the command cycle
assign last_beat = wr_kind ? cnt == BL_W'(`SDRAM_BURST - 2)
                           : cnt == BL_W'(`SDRAM_BURST - 1);

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        st      <= sdram_pkg::st_idle;
        cnt     <= '0;
        row_ok  <= 1'b0; // no row open after reset
        wr_kind <= 1'b0;
    end else begin
        case (st)
            sdram_pkg::st_idle: begin
                cnt <= '0;
                if (do_pre) st <= sdram_pkg::st_precharging;
                if (do_act) st <= sdram_pkg::st_activating;
                if (do_rw) begin
                    wr_kind <= req.we;
                    // writes put beat 0 on dq with the command
                    st <= req.we ? sdram_pkg::st_data_phase : sdram_pkg::st_accessing;
                end
            end
            sdram_pkg::st_precharging: begin
                if (cnt == BL_W'(`SDRAM_TRP - 2)) st <= sdram_pkg::st_idle;
                else cnt <= cnt + 1'd1;
            end
            sdram_pkg::st_activating: begin
                if (cnt == BL_W'(`SDRAM_TRCD - 2)) st <= sdram_pkg::st_idle;
                else cnt <= cnt + 1'd1;
            end
            sdram_pkg::st_accessing: begin
                if (cnt == BL_W'(`SDRAM_CL - 2)) begin
                    st  <= sdram_pkg::st_data_phase;
                    cnt <= '0;
                end else begin
                    cnt <= cnt + 1'd1;
                end
            end
            sdram_pkg::st_data_phase: begin
                if (last_beat) begin
                    st <= wr_kind ? sdram_pkg::st_write_done : sdram_pkg::st_idle;
                end else begin
                    cnt <= cnt + 1'd1;
                end
            end
            sdram_pkg::st_write_done: st <= sdram_pkg::st_idle; // twr
            default: st <= sdram_pkg::st_idle;
        endcase

        if (do_pre) row_ok <= 1'b0;
        if (do_act) row_ok <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (do_act) row <= req_row;
end

always_comb begin
    // command, only in a granted cycle
    if (do_pre) bus.cmd = sdram_pkg::cmd_precharge;
    else if (do_act) bus.cmd = sdram_pkg::cmd_active;
    else if (do_rw) bus.cmd = req.we ? sdram_pkg::cmd_write : sdram_pkg::cmd_read;
    else bus.cmd = sdram_pkg::cmd_nop;

    // column low bits zero, burst of four; a10 low, no auto precharge
    if (do_act) begin
        bus.addr = req_row;
    end else if (do_rw) begin
        bus.addr = {{PAD_W{1'b0}}, req.addr[`SDRAM_COL_W-1:BL_W], {BL_W{1'b0}}};
    end else begin
        bus.addr = '0; // precharge and idle, single bank only
    end

    bus.br      = br;
    // beats actually on dq; the read cas wait is covered by dqm below
    bus.dq_busy = (do_rw && req.we) || st == sdram_pkg::st_data_phase;
    // read dqm leads its data by cl cycles
    bus.dqm_busy = do_rw || st == sdram_pkg::st_accessing ||
                   (st == sdram_pkg::st_data_phase &&
                    (wr_kind || cnt < BL_W'(`SDRAM_BURST - `SDRAM_CL)));
    bus.act      = do_act;
    bus.ack      = do_rw;
    bus.dst      = (do_rw && req.we) ||
                   (st == sdram_pkg::st_data_phase && !wr_kind && cnt == '0);
    bus.dok      = (do_rw && req.we) || st == sdram_pkg::st_data_phase;
    bus.wr_burst = do_rw ? req.we : wr_kind;
end

endmodule

//--- sdram_bank/sdram_bus_arb.sv
`timescale 1ns/1ns
`include "sdram_cfg.svh"

module sdram_bus_arb (
    input  logic                    clk,
    input  logic                    rst,
    input  sdram_pkg::bank_bus_t    bus0,
    input  sdram_pkg::bank_bus_t    bus1,
    output logic                    grant0,
    output logic                    grant1,
    output logic [2:0]              others_busy0, // {dq, dqm, act} of bank 1
    output logic [2:0]              others_busy1, // {dq, dqm, act} of bank 0
    output sdram_pkg::sdram_cmd_e   cmd,
    output logic [`SDRAM_ROW_W-1:0] sdram_a,
    output logic                    ba,
    output logic                    dqm,
    output logic                    wr_sel,       // 1 when port 1 drives dq
    output logic                    dq_oe
);

localparam int ACT_W = `SDRAM_TRRD - 1; // cycles after an activate that stay banned

logic             last1;   // bank 1 won the last grant
logic [ACT_W-1:0] act_sr0; // recent activates of bank 0
logic [ACT_W-1:0] act_sr1;
logic             wr_own0; // bank 0 in a write beat
logic             wr_own1;

// round robin, only contested cycles look at the last winner
always_comb begin
    grant0 = bus0.br && (!bus1.br || last1);
    grant1 = bus1.br && (!bus0.br || !last1);
end

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        last1   <= 1'b0;
        act_sr0 <= '0;
        act_sr1 <= '0;
    end else begin
        if (grant0 || grant1) last1 <= grant1;
        act_sr0 <= (act_sr0 << 1) | ACT_W'(bus0.act);
        act_sr1 <= (act_sr1 << 1) | ACT_W'(bus1.act);
    end
end

// each bank sees only the other one's use
assign others_busy0 = {bus1.dq_busy, bus1.dqm_busy, |act_sr1};
assign others_busy1 = {bus0.dq_busy, bus0.dqm_busy, |act_sr0};

// idle engine drives nop; active low lines merge with AND
assign cmd     = sdram_pkg::sdram_cmd_e'(bus0.cmd & bus1.cmd);
assign sdram_a = bus0.addr | bus1.addr; // idle engine drives zero
assign ba      = grant1;                // a grant always issues a command

// no byte masking, dqm only high while nobody owns the burst window
assign dqm = !(bus0.dqm_busy || bus1.dqm_busy);

assign wr_own0 = bus0.dok && bus0.wr_burst;
assign wr_own1 = bus1.dok && bus1.wr_burst;
assign dq_oe   = wr_own0 || wr_own1;
assign wr_sel  = wr_own1;

endmodule

//--- source/sdram_ctrl_top.sv
`timescale 1ns/1ns
`include "sdram_cfg.svh"

module sdram_ctrl_top (
    input  logic                    clk,
    input  logic                    rst,
    // client 0, bank 0
    input  logic                    wb0_cyc,
    input  logic                    wb0_stb,
    input  logic                    wb0_we,
    input  logic [`SDRAM_AW-1:0]    wb0_adr,
    input  logic [63:0]             wb0_dat_i,
    output logic [63:0]             wb0_dat_o,
    output logic                    wb0_ack,
    // client 1, bank 1
    input  logic                    wb1_cyc,
    input  logic                    wb1_stb,
    input  logic                    wb1_we,
    input  logic [`SDRAM_AW-1:0]    wb1_adr,
    input  logic [63:0]             wb1_dat_i,
    output logic [63:0]             wb1_dat_o,
    output logic                    wb1_ack,
    // sdram pins
    output sdram_pkg::sdram_cmd_e   cmd,
    output logic [`SDRAM_ROW_W-1:0] sdram_a,
    output logic                    ba,
    output logic [15:0]             dq_out,
    output logic                    dq_oe,
    input  logic [15:0]             dq_in,
    output logic                    dqm
);

sdram_pkg::bank_req_t req0;
sdram_pkg::bank_req_t req1;
sdram_pkg::bank_bus_t bus0;
sdram_pkg::bank_bus_t bus1;
logic                 grant0;
logic                 grant1;
logic [2:0]           others_busy0; // {dq, dqm, act}
logic [2:0]           others_busy1;
logic [15:0]          wr_beat0;
logic [15:0]          wr_beat1;
logic                 wr_sel;

sdram_wb_port port0_i (
    .clk(clk), .rst(rst),
    .cyc(wb0_cyc), .stb(wb0_stb), .we(wb0_we), .adr(wb0_adr),
    .dat_i(wb0_dat_i), .dat_o(wb0_dat_o), .ack(wb0_ack),
    .req(req0), .bus(bus0), .dq_in(dq_in), .wr_beat(wr_beat0)
);

sdram_wb_port port1_i (
    .clk(clk), .rst(rst),
    .cyc(wb1_cyc), .stb(wb1_stb), .we(wb1_we), .adr(wb1_adr),
    .dat_i(wb1_dat_i), .dat_o(wb1_dat_o), .ack(wb1_ack),
    .req(req1), .bus(bus1), .dq_in(dq_in), .wr_beat(wr_beat1)
);

sdram_bank bank0_i (
    .clk(clk), .rst(rst), .req(req0), .grant(grant0),
    .all_dq_busy(others_busy0[2]), .all_dqm(others_busy0[1]), .all_act(others_busy0[0]),
    .bus(bus0)
);

sdram_bank bank1_i (
    .clk(clk), .rst(rst), .req(req1), .grant(grant1),
    .all_dq_busy(others_busy1[2]), .all_dqm(others_busy1[1]), .all_act(others_busy1[0]),
    .bus(bus1)
);

sdram_bus_arb arb_i (
    .clk(clk), .rst(rst),
    .bus0(bus0), .bus1(bus1),
    .grant0(grant0), .grant1(grant1),
    .others_busy0(others_busy0), .others_busy1(others_busy1),
    .cmd(cmd), .sdram_a(sdram_a), .ba(ba), .dqm(dqm),
    .wr_sel(wr_sel), .dq_oe(dq_oe)
);

assign dq_out = wr_sel ? wr_beat1 : wr_beat0; // write beat owner

endmodule

//--- source/sdram_wb_port.sv
`timescale 1ns/1ns
`include "sdram_cfg.svh"

module sdram_wb_port (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  logic [`SDRAM_AW-1:0] adr,
    input  logic [63:0]          dat_i,
    output logic [63:0]          dat_o,
    output logic                 ack,
    output sdram_pkg::bank_req_t req,
    input  sdram_pkg::bank_bus_t bus,
    input  logic [15:0]          dq_in,
    output logic [15:0]          wr_beat
);

localparam int BL_W   = $clog2(`SDRAM_BURST);
localparam int BEAT_W = 16;

logic              busy;    // wishbone cycle in progress
logic              valid;   // request not yet taken by the engine
logic              start;
logic              last;    // final beat of the burst
logic [BL_W-1:0]   beat;    // beats seen so far
logic [63:0]       wr_sh;   // write word, next beat in the low bits
logic [63:0]       rd_word; // read beats, lowest beat ends up low

// ack cycle still has stb high, do not restart on it
assign start = cyc && stb && !busy && !ack;
assign last  = bus.dok && beat == BL_W'(`SDRAM_BURST - 1);

// master holds adr and we stable until ack
assign req.valid = valid;
assign req.we    = we;
assign req.addr  = adr;

assign wr_beat = wr_sh[BEAT_W-1:0];
assign dat_o   = rd_word;

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        busy  <= 1'b0;
        valid <= 1'b0;
        ack   <= 1'b0;
        beat  <= '0;
    end else begin
        if (start) busy <= 1'b1;
        else if (ack) busy <= 1'b0;

        if (start) valid <= 1'b1;
        else if (bus.ack) valid <= 1'b0; // engine issued read/write

        ack <= last; // one cycle, after the last beat

        if (bus.dst) beat <= BL_W'(1); // dst is also the first dok
        else if (bus.dok) beat <= beat + 1'd1;
    end
end

// data path
always_ff @(posedge clk) begin
    if (start) begin
        wr_sh <= dat_i;
    end else if (bus.dok && bus.wr_burst) begin
        wr_sh <= wr_sh >> BEAT_W; // next beat down
    end

    if (bus.dok && !bus.wr_burst) begin
        rd_word <= {dq_in, rd_word[63:BEAT_W]};
    end
end

endmodule

//--- verif/sdram_model.sv
`timescale 1ns/1ns
`include "sdram_cfg.svh"

module sdram_model (
    input  logic                    clk,
    input  logic                    rst,
    input  sdram_pkg::sdram_cmd_e   cmd,
    input  logic [`SDRAM_ROW_W-1:0] sdram_a,
    input  logic                    ba,
    input  logic [15:0]             dq_out,
    input  logic                    dq_oe,
    input  logic                    dqm,
    output logic [15:0]             dq_in,
    output int                      errors
);

localparam int SAT = 15; // cycle counters stop here

logic [15:0]             mem [int unsigned]; // {ba, row, col} to one beat
logic                    row_open [2];
logic [`SDRAM_ROW_W-1:0] open_row [2];
int                      act_cnt [2];        // activates per bank
int                      pre_cnt [2];
int                      since_act;          // cycles since any activate
int                      since_pre [2];
int                      since_bact [2];     // per bank, for trcd
int unsigned             rd_base;
int unsigned             wr_base;
int                      rd_phase;           // 1 cas wait, 2 to 5 beats on dq
int                      wr_phase;           // write beats 1 to 3
logic                    rd_drv;             // model drives a read beat

initial errors = 0;

function automatic int unsigned beat_key(input logic b, input logic [`SDRAM_ROW_W-1:0] r,
                                         input logic [`SDRAM_COL_W-1:0] c);
    return {9'd0, b, r, c};
endfunction

// unwritten locations give a pattern of the full address
function automatic logic [15:0] read_word(input int unsigned k);
    if (mem.exists(k)) return mem[k];
    return 16'(k ^ (k >> 7) ^ (k >> 16));
endfunction

task automatic log_violation(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
endtask

always @(posedge clk, posedge rst) begin
    if (rst) begin
        for (int b = 0; b < 2; b++) begin
            row_open[b]   <= 1'b0; // all banks idle
            act_cnt[b]    <= 0;
            pre_cnt[b]    <= 0;
            since_pre[b]  <= SAT;
            since_bact[b] <= SAT;
        end
        since_act <= SAT;
        rd_phase  <= 0;
        wr_phase  <= 0;
        rd_drv    <= 1'b0;
        dq_in     <= '0;
    end else begin
        if (since_act < SAT) since_act <= since_act + 1;
        for (int b = 0; b < 2; b++) begin
            if (since_pre[b] < SAT) since_pre[b] <= since_pre[b] + 1;
            if (since_bact[b] < SAT) since_bact[b] <= since_bact[b] + 1;
        end
        // read beats, cl 2 after the command
        if (rd_phase >= 1 && rd_phase <= 4) begin
            dq_in    <= read_word(rd_base + rd_phase - 1);
            rd_drv   <= 1'b1;
            rd_phase <= rd_phase + 1;
        end else if (rd_phase == 5) begin
            rd_drv   <= 1'b0;
            rd_phase <= 0;
        end
        if (wr_phase != 0) begin
            mem[wr_base + wr_phase] = dq_out;
            wr_phase <= (wr_phase == 3) ? 0 : wr_phase + 1;
        end
        case (cmd)
            sdram_pkg::cmd_active: begin
                row_open[ba]   <= 1'b1;
                open_row[ba]   <= sdram_a;
                act_cnt[ba]    <= act_cnt[ba] + 1;
                since_act      <= 1;
                since_bact[ba] <= 1;
            end
            sdram_pkg::cmd_precharge: begin
                row_open[ba]  <= 1'b0;
                pre_cnt[ba]   <= pre_cnt[ba] + 1;
                since_pre[ba] <= 1;
            end
            sdram_pkg::cmd_read: begin
                rd_base  <= beat_key(ba, open_row[ba], sdram_a[`SDRAM_COL_W-1:0]);
                rd_phase <= 1;
            end
            sdram_pkg::cmd_write: begin
                mem[beat_key(ba, open_row[ba], sdram_a[`SDRAM_COL_W-1:0])] = dq_out; // beat 0
                wr_base  <= beat_key(ba, open_row[ba], sdram_a[`SDRAM_COL_W-1:0]);
                wr_phase <= 1;
            end
            default: ;
        endcase
    end
end

assert property (@(posedge clk) disable iff (rst)
    cmd == sdram_pkg::cmd_active |-> !row_open[ba] && since_pre[ba] >= `SDRAM_TRP)
    else log_violation("activate to an open bank or inside trp");
assert property (@(posedge clk) disable iff (rst)
    cmd == sdram_pkg::cmd_active |-> since_act >= `SDRAM_TRRD)
    else log_violation("two activates inside trrd");
assert property (@(posedge clk) disable iff (rst)
    (cmd == sdram_pkg::cmd_read || cmd == sdram_pkg::cmd_write) |->
        row_open[ba] && since_bact[ba] >= `SDRAM_TRCD)
    else log_violation("read or write without an open row, or inside trcd");
assert property (@(posedge clk) disable iff (rst) rd_drv |-> !dq_oe)
    else log_violation("controller drives dq during a read beat");
assert property (@(posedge clk) disable iff (rst)
    (cmd == sdram_pkg::cmd_write || wr_phase != 0) |-> dq_oe && !dqm)
    else log_violation("write beat without dq driven or with dqm high");

endmodule

//--- verif/tb_sdram_ctrl.sv
`timescale 1ns/1ns
`include "sdram_cfg.svh"

module tb_sdram_ctrl;

localparam int          RST_CYCLES = 16;
localparam int          N_PAIR     = 8;  // concurrent cycles per port
localparam int          N_RAND     = 64; // random cycles per port
localparam int          N_TXN      = 4 + 2 * N_PAIR + 2 * N_RAND;
localparam int          MAX_CYCLES = 40 * N_TXN + RST_CYCLES;
localparam logic [31:0] SEED       = 32'hc641;

logic                    clk;
logic                    rst;
logic [1:0]              cyc;          // stb follows cyc
logic [1:0]              we;
logic [`SDRAM_AW-1:0]    adr [2];
logic [63:0]             wdat [2];
logic [63:0]             rdat [2];
logic [1:0]              ack;
logic [1:0]              chk;          // read data must equal exp_dat
logic [63:0]             exp_dat [2];
sdram_pkg::sdram_cmd_e   cmd;
logic [`SDRAM_ROW_W-1:0] sdram_a;
logic                    ba;
logic [15:0]             dq_out;
logic                    dq_oe;
logic [15:0]             dq_in;
logic                    dqm;
logic [63:0]             ref_mem [2][128]; // per bank, {row, word}
logic                    ref_ok [2][128];
logic [31:0]             rng [2];
logic                    started = 1'b0;   // first stb seen
int                      cycles = 0;
int                      errors = 0;
int                      model_errors;

sdram_ctrl_top dut_i (
    .clk(clk), .rst(rst),
    .wb0_cyc(cyc[0]), .wb0_stb(cyc[0]), .wb0_we(we[0]), .wb0_adr(adr[0]),
    .wb0_dat_i(wdat[0]), .wb0_dat_o(rdat[0]), .wb0_ack(ack[0]),
    .wb1_cyc(cyc[1]), .wb1_stb(cyc[1]), .wb1_we(we[1]), .wb1_adr(adr[1]),
    .wb1_dat_i(wdat[1]), .wb1_dat_o(rdat[1]), .wb1_ack(ack[1]),
    .cmd(cmd), .sdram_a(sdram_a), .ba(ba), .dq_out(dq_out), .dq_oe(dq_oe),
    .dq_in(dq_in), .dqm(dqm)
);

sdram_model model_i (
    .clk(clk), .rst(rst), .cmd(cmd), .sdram_a(sdram_a), .ba(ba), .dq_out(dq_out),
    .dq_oe(dq_oe), .dqm(dqm), .dq_in(dq_in), .errors(model_errors)
);

initial clk = 1'b0;
always #4 clk = ~clk;

always @(posedge clk) begin
    if (cyc != 2'b00) started <= 1'b1;
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end
end

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// row in the top bits, word index above the two burst bits
function automatic logic [`SDRAM_AW-1:0] make_adr(input logic [1:0] row, input logic [4:0] word);
    return {11'd0, row, 2'd0, word, 2'd0};
endfunction

task automatic log_failure(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
endtask

// one classic cycle, called and returning 1 ns after a rising edge
task automatic wb_cycle(input int p, input logic w, input logic [1:0] row,
                        input logic [4:0] word, input logic [63:0] data);
    logic [6:0] idx;
    idx        = {row, word};
    adr[p]     = make_adr(row, word);
    we[p]      = w;
    wdat[p]    = data;
    exp_dat[p] = ref_mem[p][idx];
    chk[p]     = !w && ref_ok[p][idx]; // unwritten words are not compared
    cyc[p]     = 1'b1;
    do begin
        @(posedge clk);
        #1;
    end while (!ack[p]);
    if (w) begin
        ref_mem[p][idx] = data;
        ref_ok[p][idx]  = 1'b1;
    end
    @(posedge clk); // ack cycle ends here
    #1;
    cyc[p] = 1'b0;
    chk[p] = 1'b0;
endtask

task automatic random_traffic(input int p);
    logic [31:0] r;
    for (int i = 0; i < N_RAND; i++) begin
        rng[p] = lcg_next(rng[p]);
        r      = rng[p];
        wb_cycle(p, r[31], r[29:28], {3'b000, r[27:26]}, {r, ~r ^ 32'(i)});
    end
endtask

assert property (@(posedge clk) !started |-> ack == 2'b00 && cmd == sdram_pkg::cmd_nop && !dq_oe)
    else log_failure("ack, cmd or dq_oe left the reset state before the first stb");
assert property (@(posedge clk) disable iff (rst) cmd != sdram_pkg::cmd_nop |-> cyc[ba])
    else log_failure("command on a bank whose port has no open cycle");

for (genvar g = 0; g < 2; g++) begin : g_port
    assert property (@(posedge clk) disable iff (rst) ack[g] |-> cyc[g])
        else log_failure($sformatf("port %0d ack outside a cycle", g));
    assert property (@(posedge clk) disable iff (rst) ack[g] |=> !ack[g])
        else log_failure($sformatf("port %0d ack longer than one cycle", g));
    assert property (@(posedge clk) disable iff (rst) ack[g] && chk[g] |-> rdat[g] == exp_dat[g])
        else log_failure($sformatf("port %0d read %h, expected %h", g, rdat[g], exp_dat[g]));
end

initial begin
    int pre_before;
    int act_before;
    rst = 1'b1;
    cyc = 2'b00;
    we  = 2'b00;
    chk = 2'b00;
    for (int p = 0; p < 2; p++) begin
        adr[p]     = '0;
        wdat[p]    = '0;
        exp_dat[p] = '0;
        for (int i = 0; i < 128; i++) ref_ok[p][i] = 1'b0;
    end
    rng[0] = SEED;
    rng[1] = lcg_next(SEED);
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;

    // same row, read must be a plain hit
    wb_cycle(0, 1'b1, 2'd1, 5'd3, 64'h0123_4567_89ab_cdef);
    pre_before = model_i.pre_cnt[0];
    act_before = model_i.act_cnt[0];
    wb_cycle(0, 1'b0, 2'd1, 5'd3, 64'd0);
    assert (model_i.pre_cnt[0] == pre_before && model_i.act_cnt[0] == act_before)
        else log_failure("row hit read came with a precharge or activate");

    // row 2 open, then back to row 1
    wb_cycle(0, 1'b1, 2'd2, 5'd3, 64'hfeed_0002_beef_0003);
    pre_before = model_i.pre_cnt[0];
    act_before = model_i.act_cnt[0];
    wb_cycle(0, 1'b0, 2'd1, 5'd3, 64'd0);
    assert (model_i.pre_cnt[0] == pre_before + 1 && model_i.act_cnt[0] == act_before + 1 &&
            model_i.open_row[0] == 13'd1)
        else log_failure("row miss read without precharge and activate of the new row");

    // both ports at once, writes first then reads of the same words
    for (int i = 0; i < N_PAIR; i++) begin
        rng[0] = lcg_next(rng[0]);
        rng[1] = lcg_next(rng[1]);
        fork
            wb_cycle(0, i < N_PAIR / 2, 2'(i), 5'd8, {rng[0], ~rng[0]});
            wb_cycle(1, i < N_PAIR / 2, 2'(i), 5'd8, {rng[1], rng[1] ^ 32'h5a5a_0f0f});
        join
    end

    fork
        random_traffic(0);
        random_traffic(1);
    join

    repeat (2) @(posedge clk);
    $display("errors: %0d testbench, %0d SDRAM model", errors, model_errors);
    if (errors == 0 && model_errors == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule
